/* Makefile */
# Verilator build for the 2-D convolution engine

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_conv2d
RTL_TOP   ?= conv2d_top
RTL_SRCS  ?= hw/conv_pkg.sv hw/window_line_buffer.sv hw/kernel_mac.sv \
             hw/channel_combine.sv hw/conv2d_top.sv
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Everything OK
VFLAGS    ?=
SIM_FLAGS ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
+incdir+testbench
hw/conv_pkg.sv
hw/window_line_buffer.sv
hw/kernel_mac.sv
hw/channel_combine.sv
hw/conv2d_top.sv
testbench/tb_conv2d.sv

/* hw/channel_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_combine #(
    parameter int IMG_WIDTH   = 8,
    parameter int KERNEL_SIZE = 3,
    parameter int STRIDE      = 1,
    parameter int RELU        = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  conv_pkg::pixel_t i_sum_a,
    input  conv_pkg::pixel_t i_sum_b,
    input  conv_pkg::pixel_t i_bias,
    input  logic             i_sum_valid,
    input  logic             i_sum_last,
    input  logic             i_adv,
    output conv_pkg::pixel_t o_result,
    output logic             o_valid,
    output logic             o_last
);
    import conv_pkg::*;

    // Valid windows per row
    localparam int OUT_WIDTH   = IMG_WIDTH - KERNEL_SIZE + 1;
    localparam int OUT_BITS    = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1;
    localparam int STRIDE_BITS = (STRIDE > 1) ? $clog2(STRIDE) : 1;

    localparam logic [OUT_BITS-1:0]    OUT_COL_LAST = OUT_BITS'(OUT_WIDTH - 1);
    localparam logic [STRIDE_BITS-1:0] STRIDE_LAST  = STRIDE_BITS'(STRIDE - 1);

    // Window column across the output grid
    logic [OUT_BITS-1:0]    col_pos_q;
    // Column and row position modulo STRIDE
    logic [STRIDE_BITS-1:0] col_mod_q;
    logic [STRIDE_BITS-1:0] row_mod_q;
    pixel_t                 total;
    pixel_t                 activated;
    logic                   keep;

    // Both lanes plus bias, wrapping
    assign total = i_sum_a + i_sum_b + i_bias;

    // Optional ReLU on the sign bit
    assign activated = ((RELU != 0) && total[VALUE_BITS-1]) ? '0 : total;

    // Stride grid hit, the last window always goes out
    assign keep = i_sum_valid &&
                  (((col_mod_q == STRIDE_LAST) && (row_mod_q == STRIDE_LAST)) || i_sum_last);

    // Output register
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else if (i_adv) begin
            o_valid <= keep;
            o_last  <= i_sum_valid && i_sum_last;
        end
    end

    // Result payload only changes when a result is emitted
    always_ff @(posedge clk) begin
        if (i_adv && keep) begin
            o_result <= activated;
        end
    end

    // Stride position, stepped on every valid window
    always_ff @(posedge clk) begin
        if (reset) begin
            col_pos_q <= '0;
            col_mod_q <= '0;
            row_mod_q <= '0;
        end else if (i_adv && i_sum_valid) begin
            if (i_sum_last) begin
                // Image done, grid restarts at the top left
                col_pos_q <= '0;
                col_mod_q <= '0;
                row_mod_q <= '0;
            end else if (col_pos_q == OUT_COL_LAST) begin
                // Wrap to the next output row
                col_pos_q <= '0;
                col_mod_q <= '0;
                row_mod_q <= (row_mod_q == STRIDE_LAST) ? '0 : row_mod_q + 1'b1;
            end else begin
                col_pos_q <= col_pos_q + 1'b1;
                col_mod_q <= (col_mod_q == STRIDE_LAST) ? '0 : col_mod_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/conv2d_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv2d_top #(
    parameter int IMG_WIDTH   = 8,
    parameter int KERNEL_SIZE = 3,
    parameter int STRIDE      = 1,
    parameter int RELU        = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  conv_pkg::pixel_t i_pixel_a,
    input  conv_pkg::pixel_t i_pixel_b,
    input  logic             i_valid,
    input  logic             i_last,
    input  conv_pkg::pixel_t i_weights_a [KERNEL_SIZE*KERNEL_SIZE],
    input  conv_pkg::pixel_t i_weights_b [KERNEL_SIZE*KERNEL_SIZE],
    input  conv_pkg::pixel_t i_bias,
    input  logic             o_ready,
    output logic             i_ready,
    output conv_pkg::pixel_t o_result,
    output logic             o_valid,
    output logic             o_last
);
    import conv_pkg::*;

    // Global pipeline advance, the whole datapath stalls together
    logic   adv;
    pixel_t window_a [KERNEL_SIZE*KERNEL_SIZE];
    pixel_t window_b [KERNEL_SIZE*KERNEL_SIZE];
    logic   win_valid_a;
    logic   win_valid_b;
    logic   win_last_a;
    logic   win_last_b;
    pixel_t sum_a;
    pixel_t sum_b;
    // Lanes run in lockstep, lane A flags stand for both
    logic   sum_valid_a;
    logic   sum_last_a;

    assign adv     = o_ready;
    assign i_ready = adv;

    // Lane A, channel 0
    window_line_buffer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .KERNEL_SIZE(KERNEL_SIZE)
    ) lane_a_buf (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (i_pixel_a),
        .i_valid    (i_valid),
        .i_last     (i_last),
        .i_adv      (adv),
        .o_window   (window_a),
        .o_win_valid(win_valid_a),
        .o_win_last (win_last_a)
    );

    kernel_mac #(
        .KERNEL_SIZE(KERNEL_SIZE)
    ) lane_a_mac (
        .clk        (clk),
        .reset      (reset),
        .i_window   (window_a),
        .i_weights  (i_weights_a),
        .i_win_valid(win_valid_a),
        .i_win_last (win_last_a),
        .i_adv      (adv),
        .o_sum      (sum_a),
        .o_sum_valid(sum_valid_a),
        .o_sum_last (sum_last_a)
    );

    // Lane B, channel 1
    window_line_buffer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .KERNEL_SIZE(KERNEL_SIZE)
    ) lane_b_buf (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (i_pixel_b),
        .i_valid    (i_valid),
        .i_last     (i_last),
        .i_adv      (adv),
        .o_window   (window_b),
        .o_win_valid(win_valid_b),
        .o_win_last (win_last_b)
    );

    // Flags of lane B match lane A and stay open
    kernel_mac #(
        .KERNEL_SIZE(KERNEL_SIZE)
    ) lane_b_mac (
        .clk        (clk),
        .reset      (reset),
        .i_window   (window_b),
        .i_weights  (i_weights_b),
        .i_win_valid(win_valid_b),
        .i_win_last (win_last_b),
        .i_adv      (adv),
        .o_sum      (sum_b),
        .o_sum_valid(),
        .o_sum_last ()
    );

    channel_combine #(
        .IMG_WIDTH  (IMG_WIDTH),
        .KERNEL_SIZE(KERNEL_SIZE),
        .STRIDE     (STRIDE),
        .RELU       (RELU)
    ) channel_combine_i (
        .clk        (clk),
        .reset      (reset),
        .i_sum_a    (sum_a),
        .i_sum_b    (sum_b),
        .i_bias     (i_bias),
        .i_sum_valid(sum_valid_a),
        .i_sum_last (sum_last_a),
        .i_adv      (adv),
        .o_result   (o_result),
        .o_valid    (o_valid),
        .o_last     (o_last)
    );

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Word width of pixels, weights, bias and results
    localparam int VALUE_BITS = 32;

    // Fractional bits of the Q15.16 format
    localparam int FRAC_BITS = 16;

    // Signed Q15.16 word
    typedef logic signed [VALUE_BITS-1:0] pixel_t;

    // Full-precision product of two Q15.16 words, Q31.32
    typedef logic signed [2*VALUE_BITS-1:0] product_t;

    // Line buffer fill state
    // PRIME while fewer than K-1 complete rows are stored
    typedef enum logic {
        PHASE_PRIME = 1'b0,
        PHASE_RUN   = 1'b1
    } buf_phase_t;

    // Back to Q15.16 by dropping the low fraction bits
    // Upper integer bits are discarded, so large products wrap
    function automatic pixel_t scale_product(input product_t prod);
        return pixel_t'(prod[FRAC_BITS +: VALUE_BITS]);
    endfunction

endpackage

`default_nettype wire

/* hw/kernel_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_mac #(
    parameter int KERNEL_SIZE = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  conv_pkg::pixel_t i_window [KERNEL_SIZE*KERNEL_SIZE],
    input  conv_pkg::pixel_t i_weights [KERNEL_SIZE*KERNEL_SIZE],
    input  logic             i_win_valid,
    input  logic             i_win_last,
    input  logic             i_adv,
    output conv_pkg::pixel_t o_sum,
    output logic             o_sum_valid,
    output logic             o_sum_last
);
    import conv_pkg::*;

    localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // Stage 1 products, full Q31.32 precision
    product_t prod_q [TAPS];
    logic     prod_valid_q;
    logic     prod_last_q;
    // Rescaled taps summed with wraparound
    pixel_t   tap_sum;

    // Stage 1, one multiplier per tap
    always_ff @(posedge clk) begin
        if (i_adv) begin
            for (int i = 0; i < TAPS; i++) begin
                prod_q[i] <= product_t'(i_window[i]) * product_t'(i_weights[i]);
            end
        end
    end

    // Adder tree input, each product back in Q15.16
    always_comb begin
        tap_sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            tap_sum = tap_sum + scale_product(prod_q[i]);
        end
    end

    // Stage 2 sum register
    always_ff @(posedge clk) begin
        if (i_adv) begin
            o_sum <= tap_sum;
        end
    end

    // Flags follow the data one stage per advance
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid_q <= 1'b0;
            prod_last_q  <= 1'b0;
            o_sum_valid  <= 1'b0;
            o_sum_last   <= 1'b0;
        end else if (i_adv) begin
            prod_valid_q <= i_win_valid;
            prod_last_q  <= i_win_last;
            o_sum_valid  <= prod_valid_q;
            o_sum_last   <= prod_last_q;
        end
    end

endmodule

`default_nettype wire

/* hw/window_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_line_buffer #(
    parameter int IMG_WIDTH   = 8,
    parameter int KERNEL_SIZE = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  conv_pkg::pixel_t i_pixel,
    input  logic             i_valid,
    input  logic             i_last,
    input  logic             i_adv,
    output conv_pkg::pixel_t o_window [KERNEL_SIZE*KERNEL_SIZE],
    output logic             o_win_valid,
    output logic             o_win_last
);
    import conv_pkg::*;

    // K-1 stored rows, the bottom window row comes straight from the input
    localparam int LINES    = KERNEL_SIZE - 1;
    localparam int COL_BITS = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam int ROW_BITS = (LINES > 1) ? $clog2(LINES) : 1;
    localparam int SEL_BITS = (LINES > 1) ? $clog2(LINES) : 1;

    localparam logic [COL_BITS-1:0] COL_LAST       = COL_BITS'(IMG_WIDTH - 1);
    localparam logic [COL_BITS-1:0] COL_FIRST_WIN  = COL_BITS'(KERNEL_SIZE - 1);
    localparam logic [ROW_BITS-1:0] ROW_PRIME_LAST = ROW_BITS'(KERNEL_SIZE - 2);
    localparam logic [SEL_BITS-1:0] SEL_LAST       = SEL_BITS'(LINES - 1);

    // Line RAMs, one image row each
    pixel_t              line_ram [LINES][IMG_WIDTH];
    // Column entering the window on this pixel, oldest row first
    pixel_t              new_col [KERNEL_SIZE];
    logic [COL_BITS-1:0] col_q;
    logic [ROW_BITS-1:0] row_q;
    // RAM holding the oldest row, overwritten by the current row
    logic [SEL_BITS-1:0] wr_sel_q;
    buf_phase_t          phase_q;
    logic                accept;
    logic                row_end;

    assign accept  = i_valid && i_adv;
    assign row_end = (col_q == COL_LAST);

    // Read every RAM at the current column in age order
    always_comb begin
        int ram_idx;
        for (int r = 0; r < LINES; r++) begin
            // Rotate so the oldest row lands on top
            ram_idx = int'(wr_sel_q) + r;
            if (ram_idx >= LINES) begin
                ram_idx = ram_idx - LINES;
            end
            new_col[r] = line_ram[ram_idx][col_q];
        end
        new_col[LINES] = i_pixel;
    end

    // Datapath, RAM write and window shift on each accepted pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            // Current pixel replaces the oldest row entry
            line_ram[wr_sel_q][col_q] <= i_pixel;
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                // Slide each row one column left
                for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
                    o_window[r*KERNEL_SIZE + c] <= o_window[r*KERNEL_SIZE + c + 1];
                end
                // Fresh column on the right
                o_window[r*KERNEL_SIZE + KERNEL_SIZE - 1] <= new_col[r];
            end
        end
    end

    // Position counters, priming phase and window flags
    always_ff @(posedge clk) begin
        if (reset) begin
            col_q       <= '0;
            row_q       <= '0;
            wr_sel_q    <= '0;
            phase_q     <= PHASE_PRIME;
            o_win_valid <= 1'b0;
            o_win_last  <= 1'b0;
        end else if (i_adv) begin
            // Full window once K-1 rows are stored and K columns shifted in
            o_win_valid <= accept && (phase_q == PHASE_RUN) && (col_q >= COL_FIRST_WIN);
            o_win_last  <= accept && i_last;
            if (accept) begin
                if (i_last) begin
                    // End of image, start over for the next one
                    col_q    <= '0;
                    row_q    <= '0;
                    wr_sel_q <= '0;
                    phase_q  <= PHASE_PRIME;
                end else if (row_end) begin
                    col_q    <= '0;
                    // Next row goes into the following RAM
                    wr_sel_q <= (wr_sel_q == SEL_LAST) ? '0 : wr_sel_q + 1'b1;
                    if (phase_q == PHASE_PRIME) begin
                        // Row K-2 done, all line RAMs now hold data
                        if (row_q == ROW_PRIME_LAST) begin
                            phase_q <= PHASE_RUN;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/conv_ref_model.svh */
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// Expected results in delivery order, with their last flags
pixel_t exp_results [$];
bit     exp_lasts [$];

// One kernel tap, full product shifted back by the fraction width
function automatic pixel_t scaled_tap(pixel_t pix, pixel_t weight);
    product_t prod;
    prod = product_t'(pix) * product_t'(weight);
    // Keep Q15.16, upper integer bits wrap away
    return pixel_t'(prod >>> FRAC_BITS);
endfunction

// Every full window of the current image planes, stride masked
task automatic predict_image();
    pixel_t sum_a;
    pixel_t sum_b;
    pixel_t total;
    int     top;
    int     left;
    bit     last;
    for (int r = KSIZE - 1; r < img_h; r++) begin
        for (int c = KSIZE - 1; c < IMG_W; c++) begin
            // Window corner is also the output grid position
            top   = r - KSIZE + 1;
            left  = c - KSIZE + 1;
            sum_a = '0;
            sum_b = '0;
            for (int kr = 0; kr < KSIZE; kr++) begin
                for (int kc = 0; kc < KSIZE; kc++) begin
                    sum_a += scaled_tap(img_a[(top + kr) * IMG_W + left + kc],
                                        weights_a[kr * KSIZE + kc]);
                    sum_b += scaled_tap(img_b[(top + kr) * IMG_W + left + kc],
                                        weights_b[kr * KSIZE + kc]);
                end
            end
            total = sum_a + sum_b + i_bias;
            if ((RELU != 0) && (total < 0)) begin
                total = '0;
            end
            last = (r == img_h - 1) && (c == IMG_W - 1);
            // Stride hits, plus the final window of the image
            if (((top % STRIDE == STRIDE - 1) && (left % STRIDE == STRIDE - 1)) || last) begin
                exp_results.push_back(total);
                exp_lasts.push_back(last);
            end
        end
    end
endtask

`endif

/* testbench/tb_conv2d.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv2d;
    import conv_pkg::*;

    localparam int IMG_W  = 8;
    localparam int IMG_H  = 6;
    // Odd height puts the last window off the stride grid
    localparam int LONG_H = 7;
    localparam int KSIZE  = 3;
    localparam int STRIDE = 2;
    localparam int RELU   = 1;
    localparam int TAPS   = KSIZE * KSIZE;
    localparam int MAX_PIX = IMG_W * LONG_H;
    localparam int CLK_NS = 20;
    localparam int DRAIN_CYCLES = 200;
    // Pixels of all six images, four cycles each, plus drain time as margin
    localparam int TOTAL_PIX = 4 * IMG_W * IMG_H + 2 * IMG_W * LONG_H;
    localparam int WATCHDOG_NS = (TOTAL_PIX * 4 + 5 * DRAIN_CYCLES + 100) * CLK_NS;
    localparam pixel_t ONE = 32'sh0001_0000;

    logic   clk;
    logic   reset;
    pixel_t i_pixel_a;
    pixel_t i_pixel_b;
    logic   i_valid;
    logic   i_last;
    pixel_t weights_a [TAPS];
    pixel_t weights_b [TAPS];
    pixel_t i_bias;
    logic   o_ready;
    logic   i_ready;
    pixel_t o_result;
    logic   o_valid;
    logic   o_last;
    // Image planes of the image being streamed
    pixel_t img_a [MAX_PIX];
    pixel_t img_b [MAX_PIX];
    // Rows of the image being streamed
    int     img_h;
    // Random consumer stalls when set
    logic   stall_en;
    string  cur_test;
    int     error_count;
    int     check_count;
    int     test_count;
    int     failed_tests;
    int     test_start_errors;

    `include "conv_ref_model.svh"

    conv2d_top #(
        .IMG_WIDTH  (IMG_W),
        .KERNEL_SIZE(KSIZE),
        .STRIDE     (STRIDE),
        .RELU       (RELU)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .i_pixel_a  (i_pixel_a),
        .i_pixel_b  (i_pixel_b),
        .i_valid    (i_valid),
        .i_last     (i_last),
        .i_weights_a(weights_a),
        .i_weights_b(weights_b),
        .i_bias     (i_bias),
        .o_ready    (o_ready),
        .i_ready    (i_ready),
        .o_result   (o_result),
        .o_valid    (o_valid),
        .o_last     (o_last)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Consumer ready, low about one cycle in four while stalling
    always @(negedge clk) begin
        if (stall_en) begin
            o_ready = ($urandom % 4) != 0;
        end else begin
            o_ready = 1'b1;
        end
    end

    task automatic check_result(string what, pixel_t expected, pixel_t actual);
        check_count++;
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(string what, bit expected, bit actual);
        check_count++;
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %0b, actual %0b", cur_test, what, expected, actual);
            error_count++;
        end
    endtask

    // Each delivered result against the head of the expected queue
    always @(posedge clk) begin
        pixel_t exp_val;
        bit     exp_last;
        if (!reset) begin
            // Input ready follows the consumer every cycle
            check_flag("ready", o_ready, i_ready);
        end
        if (!reset && o_valid && o_ready) begin
            if (exp_results.size() == 0) begin
                $display("Test %s delivered result %h with nothing left to expect",
                         cur_test, o_result);
                error_count++;
            end else begin
                exp_val  = exp_results.pop_front();
                exp_last = exp_lasts.pop_front();
                check_result("result", exp_val, o_result);
                check_flag("last", exp_last, o_last);
            end
        end
    end

    // Signed random Q15.16 value within +-2^range_bits LSBs
    function automatic pixel_t rand_fixed(int range_bits);
        pixel_t raw;
        raw = pixel_t'($urandom);
        return raw >>> (31 - range_bits);
    endfunction

    // Kind 0 keeps lane A positive and below 16.0
    task automatic fill_images(int kind);
        for (int p = 0; p < IMG_W * img_h; p++) begin
            case (kind)
                0:       img_a[p] = pixel_t'($urandom % 32'h0010_0000);
                default: img_a[p] = rand_fixed(19);
            endcase
            img_b[p] = rand_fixed(19);
        end
    endtask

    // Lane A below 0.5 in rows 0 to 3, between 3.0 and 4.0 below them
    task automatic fill_split_images();
        for (int p = 0; p < IMG_W * img_h; p++) begin
            if (p < 4 * IMG_W) begin
                img_a[p] = pixel_t'($urandom % (ONE / 2));
            end else begin
                img_a[p] = 3 * ONE + pixel_t'($urandom % ONE);
            end
            img_b[p] = rand_fixed(19);
        end
    endtask

    task automatic set_random_weights();
        for (int i = 0; i < TAPS; i++) begin
            weights_a[i] = rand_fixed(16);
            weights_b[i] = rand_fixed(16);
        end
        i_bias = rand_fixed(18);
    endtask

    // One pixel per accepted edge, held until i_ready
    task automatic stream_image();
        for (int p = 0; p < IMG_W * img_h; p++) begin
            @(negedge clk);
            i_valid   = 1'b1;
            i_pixel_a = img_a[p];
            i_pixel_b = img_b[p];
            i_last    = (p == IMG_W * img_h - 1);
            @(posedge clk);
            while (!i_ready) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    task automatic begin_test(string name);
        @(negedge clk);
        cur_test          = name;
        test_start_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while ((exp_results.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_results.size() != 0) begin
            $display("Test %s ended with %0d expected results never delivered",
                     cur_test, exp_results.size());
            error_count++;
            exp_results.delete();
            exp_lasts.delete();
        end
        // Time for any extra output to show up
        repeat (20) @(posedge clk);
        if (error_count == test_start_errors) begin
            $display("Test %s passed", cur_test);
        end else begin
            failed_tests++;
            $display("Test %s failed with %0d errors", cur_test, error_count - test_start_errors);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns during test %s", WATCHDOG_NS, cur_test);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h9a87));
        clk       = 1'b0;
        reset     = 1'b1;
        i_valid   = 1'b0;
        i_last    = 1'b0;
        i_pixel_a = '0;
        i_pixel_b = '0;
        i_bias    = '0;
        o_ready   = 1'b1;
        stall_en  = 1'b0;
        img_h     = IMG_H;
        cur_test  = "reset";
        for (int i = 0; i < TAPS; i++) begin
            weights_a[i] = '0;
            weights_b[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Centre tap of 1.0 passes the centre pixel through
        begin_test("identity");
        weights_a[TAPS / 2] = ONE;
        fill_images(0);
        predict_image();
        stream_image();
        idle_inputs();
        end_test();

        begin_test("random");
        set_random_weights();
        fill_images(1);
        predict_image();
        stream_image();
        idle_inputs();
        end_test();

        // Lane A weights from 0.25 to 0.5 against a bias of -4.0, lane B off
        // Upper windows sum below 2.25 and clamp, lower ones exceed 4.5 and pass
        begin_test("relu");
        for (int i = 0; i < TAPS; i++) begin
            weights_a[i] = ONE / 4 + pixel_t'($urandom % (ONE / 4));
            weights_b[i] = '0;
        end
        i_bias = -(4 * ONE);
        fill_split_images();
        predict_image();
        stream_image();
        idle_inputs();
        end_test();

        stall_en = 1'b1;
        begin_test("backpressure");
        set_random_weights();
        fill_images(1);
        predict_image();
        stream_image();
        idle_inputs();
        end_test();
        stall_en = 1'b0;

        // Two images with no gap between them, last window off the stride grid
        begin_test("last_restart");
        img_h = LONG_H;
        set_random_weights();
        fill_images(1);
        predict_image();
        stream_image();
        fill_images(1);
        predict_image();
        stream_image();
        idle_inputs();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
